// File: verilog/mem_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core-side request types shared by the memory controller
// import into any block that sees fetch or load/store requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

  // load/store opcodes, loads and stores folded into one code
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    SB  = 3'd3,
    LBU = 3'd4,
    LHU = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } ls_op_e;

  // one load/store request, held steady until ls_done
  typedef struct packed {
    ls_op_e      op;
    logic [31:0] addr;
    // store data, low byte goes out first
    logic [31:0] wdata;
  } ls_req_t;

  // which requester owns the current transfer
  typedef enum logic {
    SRC_FETCH = 1'b0,
    SRC_LS    = 1'b1
  } src_e;

endpackage

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// external byte bus widths, I/O page decode and sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bus_pkg;

  // address bus, only the low 18 bits reach the memory
  localparam int ADDR_W = 32;

  // data bus, one byte per cycle
  localparam int BYTE_W = 8;

  // I/O page number sits in mem_a[17:16]
  localparam int IO_SEL_LSB = 16;

  // transfer sequencer states
  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_READ  = 2'd1,
    S_WRITE = 2'd2,
    S_DONE  = 2'd3
  } mem_state_e;

endpackage

`default_nettype wire

// File: verilog/mem_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// arbitration between fetch and load/store, and byte sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_seq_fsm
  import mem_pkg::*, bus_pkg::*;
#(
  parameter logic [1:0] IO_PAGE = 2'd3
) (
  input  wire            clk_in,
  input  wire            rst,
  input  wire            rdy_in,
  input  wire            io_buffer_full,
  input  wire            fetch_req,
  input  wire            ls_req_valid,
  input  wire ls_req_t   ls_req,
  input  wire            issue_last,
  input  wire            cap_last,
  output logic           accept,
  output src_e           src,
  output logic [2:0]     nbytes,
  output logic           step,
  output logic           cap,
  output logic           is_write,
  output logic           fetch_done,
  output logic           ls_done
);

  mem_state_e state_q, state_d;
  src_e       src_q;
  logic       step_q;
  logic       cap_q;
  logic       ls_store;
  logic       ls_io_hold;
  logic       ls_ok;

  // uart store waits while its buffer is full, other requests go on
  always_comb begin
    ls_store   = ls_req.op inside {SB, SH, SW};
    ls_io_hold = ls_store && io_buffer_full &&
                 (ls_req.addr[IO_SEL_LSB +: 2] == IO_PAGE);
    ls_ok      = ls_req_valid && !ls_io_hold;
  end

  // load/store has priority over fetch
  assign accept = rdy_in && (state_q == S_IDLE) && (ls_ok || fetch_req);
  assign src    = ls_ok ? SRC_LS : SRC_FETCH;

  // transfer length, fetch is always a full word
  always_comb begin
    nbytes = 3'd4;
    if (ls_ok) begin
      case (ls_req.op)
        LB, LBU, SB: nbytes = 3'd1;
        LH, LHU, SH: nbytes = 3'd2;
        default:     nbytes = 3'd4;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          state_d = (ls_ok && ls_store) ? S_WRITE : S_READ;
        end
      end
      // last read byte lands one cycle after its address
      S_READ:  if (cap_q && cap_last) state_d = S_DONE;
      S_WRITE: if (step_q && issue_last) state_d = S_DONE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state_q <= S_IDLE;
      src_q   <= SRC_FETCH;
      step_q  <= 1'b0;
      cap_q   <= 1'b0;
    end else if (rdy_in) begin
      state_q <= state_d;
      if (accept) begin
        src_q <= src;
      end
      if (accept) begin
        step_q <= 1'b1;
      end else if (step_q && issue_last) begin
        step_q <= 1'b0;
      end
      // returning byte trails its address by one cycle
      cap_q <= step_q && (state_q == S_READ);
    end
  end

  assign step     = step_q;
  assign cap      = cap_q;
  assign is_write = (state_q == S_WRITE);

  // done is one ready cycle in S_DONE, routed to the owner
  assign fetch_done = rdy_in && (state_q == S_DONE) && (src_q == SRC_FETCH);
  assign ls_done    = rdy_in && (state_q == S_DONE) && (src_q == SRC_LS);

endmodule

`default_nettype wire

// File: verilog/byte_counter.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte indices for address issue and read data capture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module byte_counter (
  input  wire        clk_in,
  input  wire        rst,
  input  wire        rdy_in,
  input  wire        accept,
  input  wire  [2:0] nbytes,
  input  wire        step,
  input  wire        cap,
  output logic [1:0] issue_idx,
  output logic [1:0] cap_idx,
  output logic       issue_last,
  output logic       cap_last
);

  logic [2:0] count_q;
  logic [2:0] last_idx;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      count_q   <= 3'd0;
      issue_idx <= 2'd0;
      cap_idx   <= 2'd0;
    end else if (rdy_in) begin
      if (accept) begin
        count_q   <= nbytes;
        issue_idx <= 2'd0;
        cap_idx   <= 2'd0;
      end else begin
        // each index follows its own strobe
        if (step) issue_idx <= issue_idx + 2'd1;
        if (cap)  cap_idx   <= cap_idx + 2'd1;
      end
    end
  end

  assign last_idx   = count_q - 3'd1;
  assign issue_last = ({1'b0, issue_idx} == last_idx);
  assign cap_last   = ({1'b0, cap_idx} == last_idx);

endmodule

`default_nettype wire

// File: verilog/bus_driver.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// latches the accepted request and drives address, data and write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_driver
  import mem_pkg::*, bus_pkg::*;
(
  input  wire                clk_in,
  input  wire                rst,
  input  wire                rdy_in,
  input  wire                accept,
  input  wire src_e          src,
  input  wire [ADDR_W-1:0]   fetch_pc,
  input  wire ls_req_t       ls_req,
  input  wire                step,
  input  wire                is_write,
  input  wire [1:0]          issue_idx,
  output logic [ADDR_W-1:0]  mem_a,
  output logic [BYTE_W-1:0]  mem_dout,
  output logic               mem_wr
);

  logic [ADDR_W-1:0] base_q;
  logic [31:0]       wdata_q;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      base_q <= '0;
    end else if (rdy_in && accept) begin
      base_q <= (src == SRC_LS) ? ls_req.addr : fetch_pc;
    end
  end

  // store data only matters for a load/store source
  always_ff @(posedge clk_in) begin
    if (rdy_in && accept) begin
      wdata_q <= ls_req.wdata;
    end
  end

  // byte i goes to base+i, little endian
  assign mem_a = step ? (base_q + {{(ADDR_W-2){1'b0}}, issue_idx}) : '0;

  assign mem_dout = (step && is_write) ? wdata_q[issue_idx*BYTE_W +: BYTE_W] : '0;

  // no write may reach the bus during a pause
  assign mem_wr = step && is_write && rdy_in;

endmodule

`default_nettype wire

// File: verilog/word_assembler.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collects read bytes into a word and extends load results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module word_assembler
  import mem_pkg::*, bus_pkg::*;
(
  input  wire               clk_in,
  input  wire               rst,
  input  wire               rdy_in,
  input  wire               accept,
  input  wire src_e         src,
  input  wire ls_req_t      ls_req,
  input  wire               cap,
  input  wire [1:0]         cap_idx,
  input  wire               cap_last,
  input  wire [BYTE_W-1:0]  mem_din,
  output logic [31:0]       rdata
);

  ls_op_e      op_q;
  logic [31:0] bytes_q;
  logic [31:0] word;

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      // a fetch reads like LW
      if (accept) begin
        op_q <= (src == SRC_FETCH) ? LW : ls_req.op;
      end
      if (cap) begin
        bytes_q[cap_idx*BYTE_W +: BYTE_W] <= mem_din;
      end
    end
  end

  // final byte merged straight from the bus
  always_comb begin
    word = bytes_q;
    word[cap_idx*BYTE_W +: BYTE_W] = mem_din;
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      rdata <= 32'd0;
    end else if (rdy_in && cap && cap_last) begin
      case (op_q)
        LB:      rdata <= {{24{word[7]}}, word[7:0]};
        LH:      rdata <= {{16{word[15]}}, word[15:0]};
        LBU:     rdata <= {24'd0, word[7:0]};
        LHU:     rdata <= {16'd0, word[15:0]};
        default: rdata <= word;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory controller top, connects sequencer, counters and datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_ctrl_top
  import mem_pkg::*, bus_pkg::*;
#(
  parameter logic [1:0] IO_PAGE = 2'd3
) (
  input  wire                clk_in,
  input  wire                rst,
  input  wire                rdy_in,
  input  wire [BYTE_W-1:0]   mem_din,
  output logic [BYTE_W-1:0]  mem_dout,
  output logic [ADDR_W-1:0]  mem_a,
  output logic               mem_wr,
  input  wire                io_buffer_full,
  input  wire                fetch_req,
  input  wire [ADDR_W-1:0]   fetch_pc,
  output logic               fetch_done,
  input  wire                ls_req_valid,
  input  wire ls_req_t       ls_req,
  output logic               ls_done,
  output logic [31:0]        rdata
);

  logic       accept;
  src_e       src;
  logic [2:0] nbytes;
  logic       step;
  logic       cap;
  logic       is_write;
  logic [1:0] issue_idx;
  logic [1:0] cap_idx;
  logic       issue_last;
  logic       cap_last;

  mem_seq_fsm #(.IO_PAGE(IO_PAGE)) u_fsm (
    .clk_in(clk_in), .rst(rst), .rdy_in(rdy_in),
    .io_buffer_full(io_buffer_full),
    .fetch_req(fetch_req), .ls_req_valid(ls_req_valid), .ls_req(ls_req),
    .issue_last(issue_last), .cap_last(cap_last),
    .accept(accept), .src(src), .nbytes(nbytes),
    .step(step), .cap(cap), .is_write(is_write),
    .fetch_done(fetch_done), .ls_done(ls_done)
  );

  byte_counter u_cnt (
    .clk_in(clk_in), .rst(rst), .rdy_in(rdy_in),
    .accept(accept), .nbytes(nbytes), .step(step), .cap(cap),
    .issue_idx(issue_idx), .cap_idx(cap_idx),
    .issue_last(issue_last), .cap_last(cap_last)
  );

  bus_driver u_bus (
    .clk_in(clk_in), .rst(rst), .rdy_in(rdy_in),
    .accept(accept), .src(src), .fetch_pc(fetch_pc), .ls_req(ls_req),
    .step(step), .is_write(is_write), .issue_idx(issue_idx),
    .mem_a(mem_a), .mem_dout(mem_dout), .mem_wr(mem_wr)
  );

  word_assembler u_asm (
    .clk_in(clk_in), .rst(rst), .rdy_in(rdy_in),
    .accept(accept), .src(src), .ls_req(ls_req),
    .cap(cap), .cap_idx(cap_idx), .cap_last(cap_last),
    .mem_din(mem_din), .rdata(rdata)
  );

endmodule

`default_nettype wire

// File: dv/mem_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and completion pulse assertions, bound into the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_ctrl_props (
  input wire clk_in,
  input wire rst,
  input wire rdy_in,
  input wire mem_wr,
  input wire fetch_done,
  input wire ls_done
);

  // a paused bus carries no write
  a_no_wr_paused: assert property (@(posedge clk_in) disable iff (rst)
    !rdy_in |-> !mem_wr)
    else $error("mem_wr high while rdy_in is low");

  a_done_exclusive: assert property (@(posedge clk_in) disable iff (rst)
    !(fetch_done && ls_done))
    else $error("fetch_done and ls_done high together");

  // completions are single-cycle pulses
  a_fetch_pulse: assert property (@(posedge clk_in) disable iff (rst)
    fetch_done |=> !fetch_done)
    else $error("fetch_done longer than one cycle");

  a_ls_pulse: assert property (@(posedge clk_in) disable iff (rst)
    ls_done |=> !ls_done)
    else $error("ls_done longer than one cycle");

endmodule

bind mem_ctrl_top mem_ctrl_props u_props (
  .clk_in(clk_in), .rst(rst), .rdy_in(rdy_in), .mem_wr(mem_wr),
  .fetch_done(fetch_done), .ls_done(ls_done)
);

`default_nettype wire

// File: dv/tb_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory controller, runs table traffic
// against a byte memory model, with and without rdy_in pauses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mem_ctrl
  import mem_pkg::*;
();

  localparam int DONE_LIMIT = 100;

  typedef struct packed {
    src_e        who;
    ls_op_e      op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } stim_t;

  logic        clk_in, rst, rdy_in, io_buffer_full, mem_wr;
  logic        fetch_req, fetch_done, ls_req_valid, ls_done;
  logic [7:0]  mem_din, mem_dout;
  logic [31:0] mem_a, fetch_pc, rdata;
  ls_req_t     ls_req;

  logic [7:0]  model_mem [256];
  logic [7:0]  model_io  [256];
  logic [7:0]  shadow    [256];
  int          io_writes = 0;
  logic        gaps_on;
  logic        prev_done;
  stim_t       tbl [$];

  mem_ctrl_top #(.IO_PAGE(2'd3)) u_dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // pause roughly one cycle in four once gaps are enabled
  initial begin
    rdy_in = 1'b1;
    forever begin
      @(posedge clk_in);
      rdy_in <= gaps_on ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  // byte memory, read data one cycle after the address, held during a pause
  always @(posedge clk_in) begin
    if (mem_wr) begin
      if (mem_a[17:16] == 2'd3) begin
        model_io[mem_a[7:0]] <= mem_dout;
        io_writes <= io_writes + 1;
      end else begin
        model_mem[mem_a[7:0]] <= mem_dout;
      end
    end
    if (rdy_in) begin
      mem_din <= (mem_a[17:16] == 2'd3) ? model_io[mem_a[7:0]] : model_mem[mem_a[7:0]];
    end
  end

  // bus rules watched on every cycle
  always @(negedge clk_in) begin
    if (!rst) begin
      if (mem_wr && !rdy_in) fail_with("mem_wr was high while rdy_in was low");
      if (fetch_done && ls_done) fail_with("fetch_done and ls_done were high together");
      if (prev_done && (fetch_done || ls_done)) fail_with("a done pulse lasted two cycles");
      prev_done <= fetch_done || ls_done;
    end
  end

  task automatic fail_with(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_with($sformatf("** Error at %0t ns: %s is 0x%h, expected 0x%h",
                          $time, name, got, exp));
    end
  endtask

  function automatic int byte_count(input stim_t e);
    if (e.who == SRC_FETCH) return 4;
    case (e.op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_store(input stim_t e);
    return (e.who == SRC_LS) && (e.op inside {SB, SH, SW});
  endfunction

  // little endian word from the shadow, then sign or zero extension
  function automatic logic [31:0] expect_load(input stim_t e);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) w[8*i +: 8] = shadow[e.addr[7:0] + 8'(i)];
    if (e.who == SRC_FETCH) return w;
    case (e.op)
      LB:      return {{24{w[7]}}, w[7:0]};
      LH:      return {{16{w[15]}}, w[15:0]};
      LBU:     return {24'd0, w[7:0]};
      LHU:     return {16'd0, w[15:0]};
      default: return w;
    endcase
  endfunction

  // one store and every load opcode at the same address
  task automatic add_group(input ls_op_e st, input logic [31:0] addr, input logic [31:0] wd);
    tbl.push_back(stim_t'{SRC_LS, st, addr, wd});
    tbl.push_back(stim_t'{SRC_LS, LW, addr, 32'd0});
    tbl.push_back(stim_t'{SRC_LS, LH, addr, 32'd0});
    tbl.push_back(stim_t'{SRC_LS, LHU, addr, 32'd0});
    tbl.push_back(stim_t'{SRC_LS, LB, addr, 32'd0});
    tbl.push_back(stim_t'{SRC_LS, LBU, addr, 32'd0});
  endtask

  task automatic run_entry(input stim_t e, input logic timed);
    int   n;
    int   edges;
    logic seen;
    n = byte_count(e);
    edges = 0;
    seen = 1'b0;
    @(posedge clk_in);
    if (e.who == SRC_FETCH) begin
      fetch_req <= 1'b1;
      fetch_pc  <= e.addr;
    end else begin
      ls_req_valid <= 1'b1;
      ls_req       <= ls_req_t'{e.op, e.addr, e.wdata};
    end
    if (is_store(e)) begin
      for (int i = 0; i < n; i++) shadow[e.addr[7:0] + 8'(i)] = e.wdata[8*i +: 8];
    end
    while (!seen) begin
      @(posedge clk_in);
      edges++;
      @(negedge clk_in);
      seen = (e.who == SRC_FETCH) ? fetch_done : ls_done;
      if (!seen && edges > DONE_LIMIT) fail_with("timed out waiting for a done pulse");
    end
    // accept edge plus N byte edges, reads one more for the last capture
    if (timed) check("done latency", edges, is_store(e) ? n + 1 : n + 2);
    if (is_store(e)) begin
      for (int i = 0; i < n; i++) begin
        check("stored byte", model_mem[e.addr[7:0] + 8'(i)], shadow[e.addr[7:0] + 8'(i)]);
      end
    end else begin
      check("rdata", rdata, expect_load(e));
    end
    @(posedge clk_in);
    fetch_req    <= 1'b0;
    ls_req_valid <= 1'b0;
  endtask

  // both raised in one cycle, load/store goes first
  task automatic run_both_requesters();
    stim_t lse;
    stim_t fe;
    logic  ls_seen;
    logic  f_seen;
    logic  drop_ls;
    int    edges;
    lse = stim_t'{SRC_LS, LBU, 32'h63, 32'd0};
    fe = stim_t'{SRC_FETCH, LW, 32'h40, 32'd0};
    ls_seen = 1'b0;
    f_seen = 1'b0;
    drop_ls = 1'b0;
    edges = 0;
    @(posedge clk_in);
    fetch_req    <= 1'b1;
    fetch_pc     <= fe.addr;
    ls_req_valid <= 1'b1;
    ls_req       <= ls_req_t'{lse.op, lse.addr, lse.wdata};
    while (!f_seen) begin
      @(posedge clk_in);
      if (drop_ls) ls_req_valid <= 1'b0;
      drop_ls = 1'b0;
      edges++;
      @(negedge clk_in);
      if (ls_done) begin
        check("rdata", rdata, expect_load(lse));
        ls_seen = 1'b1;
        drop_ls = 1'b1;
      end
      if (fetch_done) begin
        if (!ls_seen) fail_with("fetch_done arrived before ls_done");
        check("rdata", rdata, expect_load(fe));
        f_seen = 1'b1;
      end
      if (!f_seen && edges > DONE_LIMIT) fail_with("timed out waiting for both done pulses");
    end
    @(posedge clk_in);
    fetch_req <= 1'b0;
  endtask

  // uart byte waits for the buffer, then lands exactly once
  task automatic run_io_store_hold();
    int base;
    int edges;
    base = io_writes;
    edges = 0;
    @(posedge clk_in);
    io_buffer_full <= 1'b1;
    ls_req_valid   <= 1'b1;
    ls_req         <= ls_req_t'{SB, 32'h0003_0010, 32'h0000_005c};
    repeat (4 + $urandom % 6) begin
      @(negedge clk_in);
      check("ls_done", ls_done, 0);
      check("I/O write count", io_writes, base);
    end
    @(posedge clk_in);
    io_buffer_full <= 1'b0;
    while (!ls_done) begin
      @(negedge clk_in);
      edges++;
      if (!ls_done && edges > DONE_LIMIT) fail_with("timed out waiting for the I/O store");
    end
    check("I/O write count", io_writes, base + 1);
    check("I/O byte", model_io[8'h10], 8'h5c);
    @(posedge clk_in);
    ls_req_valid <= 1'b0;
  endtask

  initial begin
    stim_t cur;
    void'($urandom(32'h793e));
    rst = 1'b1;
    gaps_on = 1'b0;
    prev_done = 1'b0;
    io_buffer_full = 1'b0;
    fetch_req = 1'b0;
    fetch_pc = 32'd0;
    ls_req_valid = 1'b0;
    ls_req = '0;
    mem_din = 8'd0;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = 8'(i * 37 + 11);
      model_io[i]  = 8'(i * 53 + 7);
      shadow[i]    = 8'(i * 37 + 11);
    end
    tbl.push_back(stim_t'{SRC_FETCH, LW, 32'h10, 32'd0});
    add_group(SW, 32'h20, 32'h12f4_80e9);
    add_group(SH, 32'h41, 32'h0000_7f85);
    add_group(SB, 32'h63, 32'h0000_00a6);
    tbl.push_back(stim_t'{SRC_FETCH, LW, 32'h40, 32'd0});
    repeat (2) @(posedge clk_in);
    rst <= 1'b0;
    @(negedge clk_in);
    check("mem_wr", mem_wr, 0);
    check("fetch_done", fetch_done, 0);
    check("ls_done", ls_done, 0);
    check("mem_a", mem_a, 0);
    foreach (tbl[k]) run_entry(tbl[k], 1'b1);
    run_both_requesters();
    run_io_store_hold();
    // same traffic with pauses and fresh store data
    gaps_on <= 1'b1;
    foreach (tbl[k]) begin
      cur = tbl[k];
      if (is_store(cur)) cur.wdata = cur.wdata ^ $urandom;
      run_entry(cur, 1'b0);
    end
    gaps_on <= 1'b0;
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/mem_pkg.sv
verilog/bus_pkg.sv
verilog/mem_seq_fsm.sv
verilog/byte_counter.sv
verilog/bus_driver.sv
verilog/word_assembler.sv
verilog/mem_ctrl_top.sv
dv/mem_ctrl_props.sv
dv/tb_mem_ctrl.sv

// File: Bender.yml
package:
  name: mem_ctrl

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/bus_pkg.sv
      - verilog/mem_seq_fsm.sv
      - verilog/byte_counter.sv
      - verilog/bus_driver.sv
      - verilog/word_assembler.sv
      - verilog/mem_ctrl_top.sv
  - target: test
    files:
      - dv/mem_ctrl_props.sv
      - dv/tb_mem_ctrl.sv
